/* build.f */
hdl/cache_dram_pkg.sv
hdl/dma_rr_arbiter.sv
hdl/dram_req_ctrl.sv
hdl/dram_wr_packer.sv
hdl/dram_rd_unpacker.sv
hdl/cache_dram_bridge.sv
dv/tb_clock_gen.sv
dv/dram_app_model.sv
dv/cache_dram_tb.sv

/* dv/cache_dram_golden.txt */
// One record per line: bank, op (1 write, 0 read), cache address,
// then 8 words to write or 8 words expected back
0 1 00001000 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
0 0 00001000 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
1 1 00001000 b1000000 b1000001 b1000002 b1000003 b1000004 b1000005 b1000006 b1000007
1 0 00001000 b1000000 b1000001 b1000002 b1000003 b1000004 b1000005 b1000006 b1000007
0 0 00001000 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
0 1 00002000 c2000000 c2000001 c2000002 c2000003 c2000004 c2000005 c2000006 c2000007
1 1 40003040 f3040000 f3040001 f3040002 f3040003 f3040004 f3040005 f3040006 f3040007
0 0 00002000 c2000000 c2000001 c2000002 c2000003 c2000004 c2000005 c2000006 c2000007
1 0 40003040 f3040000 f3040001 f3040002 f3040003 f3040004 f3040005 f3040006 f3040007
0 1 00002040 e2040000 e2040001 e2040002 e2040003 e2040004 e2040005 e2040006 e2040007
1 0 00001000 b1000000 b1000001 b1000002 b1000003 b1000004 b1000005 b1000006 b1000007
0 0 00002040 e2040000 e2040001 e2040002 e2040003 e2040004 e2040005 e2040006 e2040007
1 1 00003000 d3000000 d3000001 d3000002 d3000003 d3000004 d3000005 d3000006 d3000007
1 0 00003000 d3000000 d3000001 d3000002 d3000003 d3000004 d3000005 d3000006 d3000007
0 0 00001000 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007

/* dv/cache_dram_tb.sv */
`default_nettype none

module cache_dram_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_REC   = 15;
  localparam int REC_WORDS = 3 + cache_dram_pkg::BLOCK_WORDS;  // Bank, op, addr, words

  logic                                                                clk_i;
  logic                                                                reset_i;
  cache_dram_pkg::dma_pkt_t [cache_dram_pkg::NUM_CACHE-1:0]            dma_pkt_i;
  logic [cache_dram_pkg::NUM_CACHE-1:0]                                dma_pkt_v_i;
  logic [cache_dram_pkg::NUM_CACHE-1:0]                                dma_pkt_yumi_o;
  logic [cache_dram_pkg::NUM_CACHE-1:0][cache_dram_pkg::DATA_WIDTH-1:0] dma_data_o;
  logic [cache_dram_pkg::NUM_CACHE-1:0]                                dma_data_v_o;
  logic [cache_dram_pkg::NUM_CACHE-1:0]                                dma_data_ready_i;
  logic [cache_dram_pkg::NUM_CACHE-1:0][cache_dram_pkg::DATA_WIDTH-1:0] dma_data_i;
  logic [cache_dram_pkg::NUM_CACHE-1:0]                                dma_data_v_i;
  logic [cache_dram_pkg::NUM_CACHE-1:0]                                dma_data_yumi_o;
  logic                                                                app_en_o;
  logic                                                                app_rdy_i;
  cache_dram_pkg::app_cmd_e                                            app_cmd_o;
  logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0]                           app_addr_o;
  logic                                                                app_wdf_wren_o;
  logic                                                                app_wdf_rdy_i;
  logic [cache_dram_pkg::BURST_WIDTH-1:0]                              app_wdf_data_o;
  logic                                                                app_wdf_end_o;
  logic                                                                app_rd_data_valid_i;
  logic [cache_dram_pkg::BURST_WIDTH-1:0]                              app_rd_data_i;
  logic                                                                app_rd_data_end_i;

  logic [31:0]                               golden [NUM_REC*REC_WORDS];
  cache_dram_pkg::app_cmd_e                  exp_cmd_q [$];
  logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0] exp_addr_q [$];
  integer                                    seed;
  int                                        wr_cmds;
  int                                        wr_beats;

  tb_clock_gen u_clk (.clk_o(clk_i), .reset_o(reset_i));

  cache_dram_bridge DUT (.*);

  dram_app_model u_model (
    .clk_i, .reset_i,
    .app_en_i(app_en_o), .app_rdy_o(app_rdy_i), .app_cmd_i(app_cmd_o), .app_addr_i(app_addr_o),
    .app_wdf_wren_i(app_wdf_wren_o), .app_wdf_rdy_o(app_wdf_rdy_i),
    .app_wdf_data_i(app_wdf_data_o), .app_wdf_end_i(app_wdf_end_o),
    .app_rd_data_valid_o(app_rd_data_valid_i), .app_rd_data_o(app_rd_data_i),
    .app_rd_data_end_o(app_rd_data_end_i)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [cache_dram_pkg::DATA_WIDTH-1:0] exp,
                            input logic [cache_dram_pkg::DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      fail_now($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_cmd(input string name, input cache_dram_pkg::app_cmd_e exp_cmd,
                           input logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0] exp_addr,
                           input cache_dram_pkg::app_cmd_e act_cmd,
                           input logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0] act_addr);
    if (act_cmd !== exp_cmd || act_addr !== exp_addr) begin
      fail_now($sformatf("ERR %s expected %0d/%h actual %0d/%h", name, exp_cmd, exp_addr,
                         act_cmd, act_addr));
    end
  endtask

  task automatic check_idle(input string when);
    if ({app_en_o, app_wdf_wren_o, dma_pkt_yumi_o, dma_data_v_o, dma_data_yumi_o} !== '0) begin
      fail_now($sformatf("Control outputs are not idle %s", when));
    end
  endtask

  // Bank goes in the top bit, block splits into NUM_REQ commands
  function automatic void push_expected_cmds(input int b, input logic wr, input logic [31:0] addr);
    logic [31:0] a;
    for (int k = 0; k < cache_dram_pkg::NUM_REQ; k++) begin
      a = addr + k * cache_dram_pkg::CMD_BYTES;
      exp_cmd_q.push_back(wr ? cache_dram_pkg::app_cmd_write : cache_dram_pkg::app_cmd_read);
      exp_addr_q.push_back({cache_dram_pkg::cache_id_t'(b),
                            a[cache_dram_pkg::DRAM_ADDR_WIDTH-1:0]});
    end
  endfunction

  task automatic send_words(input int b, input int base);
    int idx;
    idx = 0;
    dma_data_i[b]   = golden[base+3];
    dma_data_v_i[b] = 1'b1;
    while (idx < cache_dram_pkg::BLOCK_WORDS) begin
      @(posedge clk_i);
      if (dma_data_yumi_o[b]) begin
        idx++;
      end
      #1;
      if (idx < cache_dram_pkg::BLOCK_WORDS) begin
        dma_data_i[b] = golden[base+3+idx];
      end else begin
        dma_data_v_i[b] = 1'b0;
      end
    end
  endtask

  task automatic receive_words(input int b, input int rec, input int base);
    int idx;
    idx = 0;
    while (idx < cache_dram_pkg::BLOCK_WORDS) begin
      dma_data_ready_i[b] = ($random(seed) & 3) != 0;  // Random back-pressure
      @(posedge clk_i);
      if (dma_data_v_o[b] && dma_data_ready_i[b]) begin
        check_word($sformatf("rec%0d bank%0d word%0d", rec, b, idx), golden[base+3+idx],
                   dma_data_o[b]);
        idx++;
      end
      #1;
    end
    dma_data_ready_i[b] = 1'b0;
  endtask

  task automatic run_bank(input int b);
    int                       base;
    logic                     wr;
    cache_dram_pkg::dma_pkt_t pkt;
    for (int rec = 0; rec < NUM_REC; rec++) begin
      base = rec * REC_WORDS;
      if (golden[base] == b) begin
        wr                 = golden[base+1][0];
        pkt.write_not_read = wr;
        pkt.addr           = golden[base+2];
        @(posedge clk_i);
        #1;
        dma_pkt_i[b]   = pkt;
        dma_pkt_v_i[b] = 1'b1;
        @(posedge clk_i);
        while (!dma_pkt_yumi_o[b]) @(posedge clk_i);
        push_expected_cmds(b, wr, pkt.addr);
        #1;
        dma_pkt_v_i[b] = 1'b0;
        if (wr) begin
          send_words(b, base);
        end else begin
          receive_words(b, rec, base);
        end
      end
    end
  endtask

  // Command stream and write beat framing
  initial begin
    wr_cmds  = 0;
    wr_beats = 0;
    forever begin
      @(posedge clk_i);
      if (!reset_i && app_en_o && app_rdy_i) begin
        if (exp_cmd_q.size() == 0) begin
          fail_now("A command was issued with no packet pending");
        end else begin
          check_cmd("command", exp_cmd_q.pop_front(), exp_addr_q.pop_front(), app_cmd_o,
                    app_addr_o);
        end
        if (app_cmd_o == cache_dram_pkg::app_cmd_write) wr_cmds++;
      end
      if (!reset_i && app_wdf_wren_o && app_wdf_rdy_i) begin
        if (app_wdf_end_o !== ((wr_beats % cache_dram_pkg::BURST_LEN) ==
                               cache_dram_pkg::BURST_LEN - 1)) begin
          fail_now("Write end flag is not on the last beat of a command");
        end
        wr_beats++;
      end
    end
  end

  initial begin
    repeat (NUM_REC * 200) @(posedge clk_i);
    fail_now("Timeout, the traffic did not finish");
  end

  initial begin
    seed             = 32'h3d6ba0e7;
    dma_pkt_i        = '0;
    dma_pkt_v_i      = '0;
    dma_data_ready_i = '0;
    dma_data_i       = '0;
    dma_data_v_i     = '0;
    $readmemh("dv/cache_dram_golden.txt", golden);
    @(negedge clk_i);
    while (reset_i) begin
      check_idle("during reset");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    check_idle("after reset");
    fork
      run_bank(0);
      run_bank(1);
    join
    if (wr_beats != wr_cmds * cache_dram_pkg::BURST_LEN) begin
      fail_now("Write beat count does not match the write commands");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/dram_app_model.sv */
`default_nettype none

module dram_app_model (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      app_en_i,
  output logic                                      app_rdy_o,
  input  cache_dram_pkg::app_cmd_e                  app_cmd_i,
  input  logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0] app_addr_i,
  input  logic                                      app_wdf_wren_i,
  output logic                                      app_wdf_rdy_o,
  input  logic [cache_dram_pkg::BURST_WIDTH-1:0]    app_wdf_data_i,
  input  logic                                      app_wdf_end_i,
  output logic                                      app_rd_data_valid_o,
  output logic [cache_dram_pkg::BURST_WIDTH-1:0]    app_rd_data_o,
  output logic                                      app_rd_data_end_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BEAT_BYTES = cache_dram_pkg::BURST_WIDTH / 8;

  integer seed;
  logic [cache_dram_pkg::BURST_WIDTH-1:0]    mem [logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0]];
  logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0] wr_addr_q [$];  // Writes waiting for beats
  logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0] rd_addr_q [$];
  int                                        rd_due_q [$];   // Earliest return cycle
  int                                        rd_need_q [$];  // Writes that must land first
  int                                        cycle;
  int                                        wr_beat;
  int                                        rd_beat;
  int                                        wr_taken;
  int                                        wr_done;

  // Unwritten locations return a pattern built from the whole address
  function automatic logic [cache_dram_pkg::BURST_WIDTH-1:0] read_beat(
    input logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {5'h15, a, 5'h0a, ~a};
  endfunction

  initial begin
    seed                = 32'h3d6ba0e7;
    app_rdy_o           = 1'b0;
    app_wdf_rdy_o       = 1'b0;
    app_rd_data_valid_o = 1'b0;
    app_rd_data_o       = '0;
    app_rd_data_end_o   = 1'b0;
    cycle    = 0;
    wr_beat  = 0;
    rd_beat  = 0;
    wr_taken = 0;
    wr_done  = 0;
    forever begin
      @(posedge clk_i);
      cycle++;
      if (!reset_i) begin
        if (app_en_i && app_rdy_o) begin
          if (app_cmd_i == cache_dram_pkg::app_cmd_write) begin
            wr_addr_q.push_back(app_addr_i);
            wr_taken++;
          end else begin
            rd_addr_q.push_back(app_addr_i);
            rd_due_q.push_back(cycle + 2 + ($random(seed) & 7));
            rd_need_q.push_back(wr_taken);
          end
        end
        if (app_wdf_wren_i && app_wdf_rdy_o && wr_addr_q.size() > 0) begin
          mem[wr_addr_q[0] + cache_dram_pkg::APP_ADDR_WIDTH'(BEAT_BYTES * wr_beat)] =
            app_wdf_data_i;
          wr_beat++;
          if (app_wdf_end_i) begin
            void'(wr_addr_q.pop_front());
            wr_beat = 0;
            wr_done++;
          end
        end
        if (app_rd_data_valid_o) begin
          rd_beat++;
          if (rd_beat == cache_dram_pkg::BURST_LEN) begin
            void'(rd_addr_q.pop_front());
            void'(rd_due_q.pop_front());
            void'(rd_need_q.pop_front());
            rd_beat = 0;
          end
        end
      end
      #1;
      app_rdy_o     = ($random(seed) & 3) != 0;  // Ready about three cycles in four
      app_wdf_rdy_o = ($random(seed) & 3) != 0;
      if (!reset_i && rd_addr_q.size() > 0 && cycle >= rd_due_q[0] &&
          wr_done >= rd_need_q[0]) begin
        app_rd_data_valid_o = 1'b1;
        app_rd_data_o = read_beat(rd_addr_q[0] +
                                  cache_dram_pkg::APP_ADDR_WIDTH'(BEAT_BYTES * rd_beat));
        app_rd_data_end_o = (rd_beat == cache_dram_pkg::BURST_LEN - 1);
      end else begin
        app_rd_data_valid_o = 1'b0;
        app_rd_data_end_o   = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* hdl/cache_dram_bridge.sv */
`default_nettype none

module cache_dram_bridge (
  input  logic                                                               clk_i,
  input  logic                                                               reset_i,
  input  cache_dram_pkg::dma_pkt_t [cache_dram_pkg::NUM_CACHE-1:0]           dma_pkt_i,
  input  logic [cache_dram_pkg::NUM_CACHE-1:0]                               dma_pkt_v_i,
  output logic [cache_dram_pkg::NUM_CACHE-1:0]                               dma_pkt_yumi_o,
  output logic [cache_dram_pkg::NUM_CACHE-1:0][cache_dram_pkg::DATA_WIDTH-1:0] dma_data_o,
  output logic [cache_dram_pkg::NUM_CACHE-1:0]                               dma_data_v_o,
  input  logic [cache_dram_pkg::NUM_CACHE-1:0]                               dma_data_ready_i,
  input  logic [cache_dram_pkg::NUM_CACHE-1:0][cache_dram_pkg::DATA_WIDTH-1:0] dma_data_i,
  input  logic [cache_dram_pkg::NUM_CACHE-1:0]                               dma_data_v_i,
  output logic [cache_dram_pkg::NUM_CACHE-1:0]                               dma_data_yumi_o,
  output logic                                                               app_en_o,
  input  logic                                                               app_rdy_i,
  output cache_dram_pkg::app_cmd_e                                           app_cmd_o,
  output logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0]                          app_addr_o,
  output logic                                                               app_wdf_wren_o,
  input  logic                                                               app_wdf_rdy_i,
  output logic [cache_dram_pkg::BURST_WIDTH-1:0]                             app_wdf_data_o,
  output logic                                                               app_wdf_end_o,
  input  logic                                                               app_rd_data_valid_i,
  input  logic [cache_dram_pkg::BURST_WIDTH-1:0]                             app_rd_data_i,
  input  logic                                                               app_rd_data_end_i
);

  logic                      arb_v;
  cache_dram_pkg::dma_pkt_t  arb_pkt;
  cache_dram_pkg::cache_id_t arb_id;
  logic                      arb_yumi;
  logic                      wr_v;
  cache_dram_pkg::cache_id_t wr_id;
  logic                      wr_ready;
  logic                      rd_v;
  cache_dram_pkg::cache_id_t rd_id;
  logic                      rd_ready;

  dma_rr_arbiter u_arb (
    .clk_i, .reset_i,
    .pkt_i(dma_pkt_i), .v_i(dma_pkt_v_i), .yumi_o(dma_pkt_yumi_o),
    .v_o(arb_v), .pkt_o(arb_pkt), .id_o(arb_id), .yumi_i(arb_yumi)
  );

  dram_req_ctrl u_ctrl (
    .clk_i, .reset_i,
    .arb_v_i(arb_v), .arb_pkt_i(arb_pkt), .arb_id_i(arb_id), .arb_yumi_o(arb_yumi),
    .app_en_o, .app_rdy_i, .app_cmd_o, .app_addr_o,
    .wr_v_o(wr_v), .wr_id_o(wr_id), .wr_ready_i(wr_ready),
    .rd_v_o(rd_v), .rd_id_o(rd_id), .rd_ready_i(rd_ready)
  );

  dram_wr_packer u_wr (
    .clk_i, .reset_i,
    .v_i(wr_v), .id_i(wr_id), .ready_o(wr_ready),
    .dma_data_i, .dma_data_v_i, .dma_data_yumi_o,
    .app_wdf_wren_o, .app_wdf_rdy_i, .app_wdf_data_o, .app_wdf_end_o
  );

  dram_rd_unpacker u_rd (
    .clk_i, .reset_i,
    .v_i(rd_v), .id_i(rd_id), .ready_o(rd_ready),
    .app_rd_data_valid_i, .app_rd_data_i, .app_rd_data_end_i,
    .dma_data_o, .dma_data_v_o, .dma_data_ready_i
  );

endmodule

`default_nettype wire

/* hdl/dram_rd_unpacker.sv */
`default_nettype none

module dram_rd_unpacker (
  input  logic                                                               clk_i,
  input  logic                                                               reset_i,
  input  logic                                                               v_i,
  input  cache_dram_pkg::cache_id_t                                          id_i,
  output logic                                                               ready_o,
  input  logic                                                               app_rd_data_valid_i,
  input  logic [cache_dram_pkg::BURST_WIDTH-1:0]                             app_rd_data_i,
  input  logic                                                               app_rd_data_end_i,
  output logic [cache_dram_pkg::NUM_CACHE-1:0][cache_dram_pkg::DATA_WIDTH-1:0] dma_data_o,
  output logic [cache_dram_pkg::NUM_CACHE-1:0]                               dma_data_v_o,
  input  logic [cache_dram_pkg::NUM_CACHE-1:0]                               dma_data_ready_i
);

  cache_dram_pkg::cache_id_t                    tag_mem [cache_dram_pkg::RD_OUTSTANDING];
  logic [cache_dram_pkg::TAG_PTR_WIDTH-1:0]     tag_wptr_r;
  logic [cache_dram_pkg::TAG_PTR_WIDTH-1:0]     tag_rptr_r;
  logic [cache_dram_pkg::TAG_PTR_WIDTH:0]       tag_cnt_r;
  logic [cache_dram_pkg::BURST_WIDTH:0]         beat_mem [cache_dram_pkg::RD_BUF_DEPTH];  // End on top
  logic [cache_dram_pkg::RD_BUF_PTR_WIDTH-1:0]  buf_wptr_r;
  logic [cache_dram_pkg::RD_BUF_PTR_WIDTH-1:0]  buf_rptr_r;
  logic [cache_dram_pkg::RD_BUF_PTR_WIDTH:0]    buf_cnt_r;
  logic [cache_dram_pkg::WORD_SEL_WIDTH-1:0]    word_sel_r;  // Half of head beat to send
  logic [cache_dram_pkg::BURST_WIDTH:0]         head_beat;
  cache_dram_pkg::cache_id_t                    head_tag;
  logic                                         buf_v;
  logic                                         word_fire;
  logic                                         beat_pop;
  logic                                         tag_pop;

  assign ready_o   = (tag_cnt_r !=
                      (cache_dram_pkg::TAG_PTR_WIDTH + 1)'(cache_dram_pkg::RD_OUTSTANDING));
  assign head_beat = beat_mem[buf_rptr_r];
  assign head_tag  = tag_mem[tag_rptr_r];
  assign buf_v     = (buf_cnt_r != '0);

  assign word_fire = buf_v & dma_data_ready_i[head_tag];
  assign beat_pop  = word_fire & (word_sel_r ==
                     cache_dram_pkg::WORD_SEL_WIDTH'(cache_dram_pkg::WORDS_PER_BEAT - 1));
  assign tag_pop   = beat_pop & head_beat[cache_dram_pkg::BURST_WIDTH];  // Command complete

  always_comb begin
    for (int i = 0; i < cache_dram_pkg::NUM_CACHE; i++) begin
      dma_data_o[i]   = head_beat[word_sel_r*cache_dram_pkg::DATA_WIDTH +:
                                  cache_dram_pkg::DATA_WIDTH];
      dma_data_v_o[i] = buf_v & (head_tag == cache_dram_pkg::cache_id_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      tag_mem[tag_wptr_r] <= id_i;
    end
    if (app_rd_data_valid_i) begin
      beat_mem[buf_wptr_r] <= {app_rd_data_end_i, app_rd_data_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_wptr_r <= '0;
      tag_rptr_r <= '0;
      tag_cnt_r  <= '0;
      buf_wptr_r <= '0;
      buf_rptr_r <= '0;
      buf_cnt_r  <= '0;
      word_sel_r <= '0;
    end else begin
      tag_wptr_r <= tag_wptr_r + v_i;
      tag_rptr_r <= tag_rptr_r + tag_pop;
      tag_cnt_r  <= tag_cnt_r + v_i - tag_pop;
      buf_wptr_r <= buf_wptr_r + app_rd_data_valid_i;
      buf_rptr_r <= buf_rptr_r + beat_pop;
      buf_cnt_r  <= buf_cnt_r + app_rd_data_valid_i - beat_pop;
      if (word_fire) begin
        word_sel_r <= beat_pop ? '0 : word_sel_r + 1'b1;
      end
    end
  end

  a_beat_has_tag: assert property (@(posedge clk_i) disable iff (reset_i)
    app_rd_data_valid_i |-> (tag_cnt_r != '0))
    else $error("rd_unpacker: read beat with no outstanding command");

  a_buf_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (app_rd_data_valid_i && (buf_cnt_r == cache_dram_pkg::RD_BUF_DEPTH)) |-> beat_pop)
    else $error("rd_unpacker: beat buffer overflow");

endmodule

`default_nettype wire

/* hdl/dram_wr_packer.sv */
`default_nettype none

module dram_wr_packer (
  input  logic                                                              clk_i,
  input  logic                                                              reset_i,
  input  logic                                                              v_i,
  input  cache_dram_pkg::cache_id_t                                         id_i,
  output logic                                                              ready_o,
  input  logic [cache_dram_pkg::NUM_CACHE-1:0][cache_dram_pkg::DATA_WIDTH-1:0] dma_data_i,
  input  logic [cache_dram_pkg::NUM_CACHE-1:0]                              dma_data_v_i,
  output logic [cache_dram_pkg::NUM_CACHE-1:0]                              dma_data_yumi_o,
  output logic                                                              app_wdf_wren_o,
  input  logic                                                              app_wdf_rdy_i,
  output logic [cache_dram_pkg::BURST_WIDTH-1:0]                            app_wdf_data_o,
  output logic                                                              app_wdf_end_o
);

  logic                                        q_v_r;  // One pending write command
  cache_dram_pkg::cache_id_t                   q_id_r;
  logic [cache_dram_pkg::BURST_WIDTH-1:0]      beat_r;
  logic                                        beat_full_r;
  logic [cache_dram_pkg::WORD_SEL_WIDTH-1:0]   word_cnt_r;
  logic [cache_dram_pkg::BEAT_CNT_WIDTH-1:0]   beat_cnt_r;
  logic                                        collect;
  logic                                        word_take;
  logic                                        last_word;
  logic                                        last_beat;
  logic                                        beat_sent;

  assign ready_o = ~q_v_r;
  assign collect = q_v_r & ~beat_full_r;

  always_comb begin
    for (int i = 0; i < cache_dram_pkg::NUM_CACHE; i++) begin
      dma_data_yumi_o[i] = collect & dma_data_v_i[i] &
                           (q_id_r == cache_dram_pkg::cache_id_t'(i));
    end
  end

  assign word_take = |dma_data_yumi_o;
  assign last_word = (word_cnt_r ==
                      cache_dram_pkg::WORD_SEL_WIDTH'(cache_dram_pkg::WORDS_PER_BEAT - 1));
  assign last_beat = (beat_cnt_r ==
                      cache_dram_pkg::BEAT_CNT_WIDTH'(cache_dram_pkg::BURST_LEN - 1));

  assign app_wdf_wren_o = beat_full_r;
  assign app_wdf_data_o = beat_r;
  assign app_wdf_end_o  = beat_full_r & last_beat;
  assign beat_sent      = app_wdf_wren_o & app_wdf_rdy_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      q_v_r       <= 1'b0;
      beat_full_r <= 1'b0;
      word_cnt_r  <= '0;
      beat_cnt_r  <= '0;
    end else begin
      if (v_i) begin
        q_v_r <= 1'b1;
      end else if (beat_sent && last_beat) begin
        q_v_r <= 1'b0;  // Command finished
      end
      if (word_take) begin
        word_cnt_r <= last_word ? '0 : word_cnt_r + 1'b1;
        if (last_word) begin
          beat_full_r <= 1'b1;
        end
      end else if (beat_sent) begin
        beat_full_r <= 1'b0;
      end
      if (beat_sent) begin
        beat_cnt_r <= last_beat ? '0 : beat_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      q_id_r <= id_i;
    end
    if (word_take) begin
      beat_r[word_cnt_r*cache_dram_pkg::DATA_WIDTH +: cache_dram_pkg::DATA_WIDTH] <=
        dma_data_i[q_id_r];  // Low word first
    end
  end

  a_yumi_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(dma_data_yumi_o))
    else $error("wr_packer: more than one bank consumed");

endmodule

`default_nettype wire

/* hdl/dram_req_ctrl.sv */
`default_nettype none

module dram_req_ctrl (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        arb_v_i,
  input  cache_dram_pkg::dma_pkt_t                    arb_pkt_i,
  input  cache_dram_pkg::cache_id_t                   arb_id_i,
  output logic                                        arb_yumi_o,
  output logic                                        app_en_o,
  input  logic                                        app_rdy_i,
  output cache_dram_pkg::app_cmd_e                    app_cmd_o,
  output logic [cache_dram_pkg::APP_ADDR_WIDTH-1:0]   app_addr_o,
  output logic                                        wr_v_o,
  output cache_dram_pkg::cache_id_t                   wr_id_o,
  input  logic                                        wr_ready_i,
  output logic                                        rd_v_o,
  output cache_dram_pkg::cache_id_t                   rd_id_o,
  input  logic                                        rd_ready_i
);

  typedef enum logic {
    st_idle,
    st_send
  } state_e;

  state_e                                     state_r;
  logic [cache_dram_pkg::REQ_CNT_WIDTH-1:0]   req_cnt_r;  // Commands already taken
  logic [cache_dram_pkg::ADDR_WIDTH-1:0]      addr_r;
  cache_dram_pkg::cache_id_t                  id_r;
  logic                                       write_r;
  logic                                       sending;
  logic                                       cmd_fire;
  logic                                       last_cmd;

  assign sending    = (state_r == st_send);
  assign arb_yumi_o = (state_r == st_idle) & arb_v_i;

  // Hold off the command until the unit that will move its data can take it
  assign app_en_o   = sending & (write_r ? wr_ready_i : rd_ready_i);
  assign app_cmd_o  = (sending & write_r) ? cache_dram_pkg::app_cmd_write
                                          : cache_dram_pkg::app_cmd_read;
  assign app_addr_o = {id_r, addr_r[cache_dram_pkg::DRAM_ADDR_WIDTH-1:0]};  // Bank picks region

  assign cmd_fire = app_en_o & app_rdy_i;
  assign last_cmd = (req_cnt_r == cache_dram_pkg::REQ_CNT_WIDTH'(cache_dram_pkg::NUM_REQ - 1));

  assign wr_v_o  = cmd_fire & write_r;
  assign wr_id_o = id_r;
  assign rd_v_o  = cmd_fire & ~write_r;
  assign rd_id_o = id_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= st_idle;
      req_cnt_r <= '0;
    end else begin
      case (state_r)
        st_idle: begin
          if (arb_v_i) begin
            state_r   <= st_send;
            req_cnt_r <= '0;
          end
        end
        st_send: begin
          if (cmd_fire) begin
            req_cnt_r <= req_cnt_r + 1'b1;
            if (last_cmd) begin
              state_r <= st_idle;  // Whole block issued
            end
          end
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (arb_yumi_o) begin
      addr_r  <= arb_pkt_i.addr;
      id_r    <= arb_id_i;
      write_r <= arb_pkt_i.write_not_read;
    end else if (cmd_fire) begin
      addr_r <= addr_r + cache_dram_pkg::ADDR_WIDTH'(cache_dram_pkg::CMD_BYTES);  // Next group
    end
  end

  a_no_cmd_in_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == st_idle) |-> !app_en_o)
    else $error("req_ctrl: command enabled while idle");

endmodule

`default_nettype wire

/* hdl/dma_rr_arbiter.sv */
`default_nettype none

module dma_rr_arbiter (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  cache_dram_pkg::dma_pkt_t [cache_dram_pkg::NUM_CACHE-1:0] pkt_i,
  input  logic [cache_dram_pkg::NUM_CACHE-1:0]                v_i,
  output logic [cache_dram_pkg::NUM_CACHE-1:0]                yumi_o,
  output logic                                                v_o,
  output cache_dram_pkg::dma_pkt_t                            pkt_o,
  output cache_dram_pkg::cache_id_t                           id_o,
  input  logic                                                yumi_i
);

  cache_dram_pkg::cache_id_t ptr_r;  // Bank with top priority

  always_comb begin
    v_o  = 1'b0;
    id_o = ptr_r;
    // Walk down from the farthest offset so the nearest valid bank wins
    for (int i = cache_dram_pkg::NUM_CACHE - 1; i >= 0; i--) begin
      int idx;
      idx = (int'(ptr_r) + i) % cache_dram_pkg::NUM_CACHE;
      if (v_i[idx]) begin
        v_o  = 1'b1;
        id_o = cache_dram_pkg::cache_id_t'(idx);
      end
    end
  end

  assign pkt_o = pkt_i[id_o];

  always_comb begin
    for (int i = 0; i < cache_dram_pkg::NUM_CACHE; i++) begin
      yumi_o[i] = yumi_i & (id_o == cache_dram_pkg::cache_id_t'(i));  // Winner only
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r <= '0;
    end else if (yumi_i) begin
      ptr_r <= cache_dram_pkg::cache_id_t'((int'(id_o) + 1) % cache_dram_pkg::NUM_CACHE);
    end
  end

  // The control block may only accept a packet that is on offer
  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o)
    else $error("arbiter: yumi without a valid packet");

endmodule

`default_nettype wire

/* hdl/cache_dram_pkg.sv */
`default_nettype none

package cache_dram_pkg;

  localparam int NUM_CACHE      = 2;
  localparam int CACHE_ID_WIDTH = 1;
  localparam int ADDR_WIDTH     = 32;  // Cache side byte address
  localparam int DATA_WIDTH     = 32;
  localparam int BLOCK_WORDS    = 8;
  localparam int BURST_WIDTH    = 64;  // Controller data beat
  localparam int BURST_LEN      = 2;

  localparam int WORDS_PER_BEAT = BURST_WIDTH / DATA_WIDTH;
  localparam int NUM_REQ        = (DATA_WIDTH * BLOCK_WORDS) / (BURST_WIDTH * BURST_LEN);
  localparam int CMD_BYTES      = (BURST_WIDTH * BURST_LEN) / 8;

  localparam int DRAM_ADDR_WIDTH = 26;  // Region owned by one bank
  localparam int APP_ADDR_WIDTH  = DRAM_ADDR_WIDTH + CACHE_ID_WIDTH;

  localparam int RD_OUTSTANDING = 4;
  localparam int RD_BUF_DEPTH   = RD_OUTSTANDING * BURST_LEN;

  // Counter and pointer widths
  localparam int REQ_CNT_WIDTH    = $clog2(NUM_REQ);
  localparam int WORD_SEL_WIDTH   = $clog2(WORDS_PER_BEAT);
  localparam int BEAT_CNT_WIDTH   = $clog2(BURST_LEN);
  localparam int TAG_PTR_WIDTH    = $clog2(RD_OUTSTANDING);
  localparam int RD_BUF_PTR_WIDTH = $clog2(RD_BUF_DEPTH);

  typedef logic [CACHE_ID_WIDTH-1:0] cache_id_t;

  typedef struct packed {
    logic                  write_not_read;
    logic [ADDR_WIDTH-1:0] addr;
  } dma_pkt_t;

  // Encoding as on the controller app port
  typedef enum logic [2:0] {
    app_cmd_write = 3'b000,
    app_cmd_read  = 3'b001
  } app_cmd_e;

endpackage

`default_nettype wire
